// ==== common/apogeo_data_pkg.sv ====
`default_nettype none

package apogeo_data_pkg;

    // --------------------
    // Datapath sizing
    // --------------------

    // Integer register width of the core
    localparam int XLEN       = 32;
    // Bits needed to index one bit of a word
    localparam int XLEN_LOG   = $clog2(XLEN);
    // Bytes per word, used by ORC.B and REV8
    localparam int XLEN_BYTES = XLEN / 8;

    // Result buffer depth, equal to the sender's starting credits
    localparam int BMU_CREDITS = 4;
    // Read and write pointer width of the result buffer
    localparam int BMU_PTR_W   = $clog2(BMU_CREDITS);

    // One data word, seen either whole or byte by byte
    typedef union packed {
        logic [XLEN-1:0]                 word32;
        logic [XLEN_BYTES-1:0][7:0]      word8;
    } data_word_t;

endpackage : apogeo_data_pkg

`default_nettype wire

// ==== common/bmu_op_pkg.sv ====
`default_nettype none

package bmu_op_pkg;

    // Width of the per-group opcode field
    localparam int OPCODE_W = 3;

    // Operation group, picks the final result mux input
    typedef enum logic [2:0] {
        SHADD,
        COUNT,
        COMPARE,
        EXTEND,
        ROTATE,
        BYTEOP,
        LOGICOP
    } bmu_valid_uop_t;

    // --------------------
    // Opcodes per group
    // --------------------
    typedef enum logic [OPCODE_W-1:0] { SH1ADD, SH2ADD, SH3ADD } bmu_shadd_uop_t;
    typedef enum logic [OPCODE_W-1:0] { CLZ, CTZ, CPOP } bmu_count_uop_t;
    typedef enum logic [OPCODE_W-1:0] { MAX, MAXU, MIN, MINU } bmu_cmp_uop_t;
    typedef enum logic [OPCODE_W-1:0] { ZEXTH, SEXTB, SEXTH } bmu_ext_uop_t;
    typedef enum logic [OPCODE_W-1:0] { ROL, ROR } bmu_rot_uop_t;
    typedef enum logic [OPCODE_W-1:0] { ORCB, REV8 } bmu_byte_uop_t;
    typedef enum logic [OPCODE_W-1:0] {
        ANDN, ORN, XNOR, BCLR, BEXT, BINV, BSET
    } bmu_logic_uop_t;

    // Opcode is decoded through the enum of op_type's group
    typedef struct packed {
        bmu_valid_uop_t        op_type;
        logic [OPCODE_W-1:0]   opcode;
    } bmu_uop_t;

    // One request from the issuing stage
    typedef struct packed {
        apogeo_data_pkg::data_word_t operand_a;
        apogeo_data_pkg::data_word_t operand_b;
        bmu_uop_t                    uop;
    } bmu_req_t;

endpackage : bmu_op_pkg

`default_nettype wire

// ==== bit_manipulation/count_leading_zeros.sv ====
`default_nettype none

module count_leading_zeros #(
    parameter int WIDTH = 32
) (
    input  wire logic [WIDTH-1:0]         operand_i,
    output logic      [$clog2(WIDTH)-1:0] lz_count_o,
    output logic                          is_all_zero_o
);

    // Priority search, the highest set bit is visited last and wins
    always_comb begin : lz_search
        lz_count_o = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (operand_i[i]) begin
                // Zeros above bit i
                lz_count_o = ($clog2(WIDTH))'(WIDTH - 1 - i);
            end
        end
    end : lz_search

    // WIDTH leading zeros does not fit lz_count_o, so flag it apart
    assign is_all_zero_o = ~|operand_i;

endmodule : count_leading_zeros

`default_nettype wire

// ==== bit_manipulation/population_count.sv ====
`default_nettype none

module population_count #(
    parameter int WIDTH = 32
) (
    input  wire logic [WIDTH-1:0]       operand_i,
    output logic      [$clog2(WIDTH):0] count_o
);

    // Running sum, entry i holds the set bits below bit i
    logic [$clog2(WIDTH):0] partial_sum [WIDTH+1];

    assign partial_sum[0] = '0;

    // One adder per bit, chained from bit 0 upward
    for (genvar i = 0; i < WIDTH; i++) begin : g_adder_chain
        assign partial_sum[i+1] = partial_sum[i] + {{$clog2(WIDTH){1'b0}}, operand_i[i]};
    end : g_adder_chain

    assign count_o = partial_sum[WIDTH];

endmodule : population_count

`default_nettype wire

// ==== bit_manipulation/bit_manipulation_unit.sv ====
`default_nettype none

module bit_manipulation_unit (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  req_valid_i,
    input  wire bmu_op_pkg::bmu_req_t  req_i,
    output apogeo_data_pkg::data_word_t result_o,
    output logic                       data_valid_o
);

    import apogeo_data_pkg::*;
    import bmu_op_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN_LOG-1:0] bit_idx;

    // Operand shorthands, bit index is operand_b[4:0]
    assign op_a    = req_i.operand_a.word32;
    assign op_b    = req_i.operand_b.word32;
    assign bit_idx = op_b[XLEN_LOG-1:0];

    // Opcode seen through each group's enum
    bmu_shadd_uop_t shadd_op;
    bmu_count_uop_t count_op;
    bmu_cmp_uop_t   cmp_op;
    bmu_ext_uop_t   ext_op;
    bmu_rot_uop_t   rot_op;
    bmu_byte_uop_t  byte_op;
    bmu_logic_uop_t logic_op;

    assign shadd_op = bmu_shadd_uop_t'(req_i.uop.opcode);
    assign count_op = bmu_count_uop_t'(req_i.uop.opcode);
    assign cmp_op   = bmu_cmp_uop_t'(req_i.uop.opcode);
    assign ext_op   = bmu_ext_uop_t'(req_i.uop.opcode);
    assign rot_op   = bmu_rot_uop_t'(req_i.uop.opcode);
    assign byte_op  = bmu_byte_uop_t'(req_i.uop.opcode);
    assign logic_op = bmu_logic_uop_t'(req_i.uop.opcode);

    // --------------------
    // Count group
    // --------------------
    logic [XLEN-1:0]     reversed_a;
    logic [XLEN-1:0]     clz_operand;
    logic [XLEN_LOG-1:0] lz_count;
    logic                all_zero;
    logic [XLEN_LOG:0]   cpop_count;

    // CTZ is CLZ of the mirrored operand
    always_comb begin : mirror_operand
        for (int i = 0; i < XLEN; i++) begin
            reversed_a[XLEN-1-i] = op_a[i];
        end
    end : mirror_operand

    assign clz_operand = (count_op == CTZ) ? reversed_a : op_a;

    count_leading_zeros #(.WIDTH(XLEN)) u_clz (
        .operand_i     (clz_operand),
        .lz_count_o    (lz_count),
        .is_all_zero_o (all_zero)
    );

    population_count #(.WIDTH(XLEN)) u_cpop (
        .operand_i (op_a),
        .count_o   (cpop_count)
    );

    // Combinational result of every group, ahead of its stage register
    logic [XLEN-1:0]   shadd_d, cmp_d, ext_d, rot_d, byte_d, logic_d;
    logic [XLEN_LOG:0] count_d;
    logic [1:0]        shadd_amt;
    logic [XLEN-1:0]   bit_mask;
    data_word_t        orcb_word, rev8_word;

    assign bit_mask = {{(XLEN-1){1'b0}}, 1'b1} << bit_idx;

    always_comb begin : group_results
        // SHnADD, shift amount is the n of the mnemonic
        case (shadd_op)
            SH1ADD:  shadd_amt = 2'd1;
            SH2ADD:  shadd_amt = 2'd2;
            SH3ADD:  shadd_amt = 2'd3;
            default: shadd_amt = 2'd0;
        endcase
        shadd_d = op_b + (op_a << shadd_amt);

        // All-zero word counts 32, the only value with the top bit set
        if (count_op == CPOP)  count_d = cpop_count;
        else if (all_zero)     count_d = {1'b1, {XLEN_LOG{1'b0}}};
        else                   count_d = {1'b0, lz_count};

        case (cmp_op)
            MAX:     cmp_d = ($signed(op_a) < $signed(op_b)) ? op_b : op_a;
            MAXU:    cmp_d = (op_a < op_b) ? op_b : op_a;
            MIN:     cmp_d = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
            MINU:    cmp_d = (op_a < op_b) ? op_a : op_b;
            default: cmp_d = '0;
        endcase

        case (ext_op)
            SEXTB:   ext_d = {{(XLEN-8){op_a[7]}}, op_a[7:0]};
            SEXTH:   ext_d = {{(XLEN-16){op_a[15]}}, op_a[15:0]};
            default: ext_d = {{(XLEN-16){1'b0}}, op_a[15:0]};
        endcase

        // Shift by XLEN - 0 clears the wrap term, so rotate by 0 passes through
        if (rot_op == ROR) rot_d = (op_a >> bit_idx) | (op_a << (XLEN - bit_idx));
        else               rot_d = (op_a << bit_idx) | (op_a >> (XLEN - bit_idx));

        // Byte-wise OR-combine and byte reversal
        for (int i = 0; i < XLEN_BYTES; i++) begin
            orcb_word.word8[i]                = {8{|req_i.operand_a.word8[i]}};
            rev8_word.word8[XLEN_BYTES-1-i]   = req_i.operand_a.word8[i];
        end
        byte_d = (byte_op == REV8) ? rev8_word.word32 : orcb_word.word32;

        // Negated-operand logic and single-bit operations
        case (logic_op)
            ANDN:    logic_d = op_a & ~op_b;
            ORN:     logic_d = op_a | ~op_b;
            XNOR:    logic_d = ~(op_a ^ op_b);
            BCLR:    logic_d = op_a & ~bit_mask;
            BEXT:    logic_d = {{(XLEN-1){1'b0}}, op_a[bit_idx]};
            BINV:    logic_d = op_a ^ bit_mask;
            BSET:    logic_d = op_a | bit_mask;
            default: logic_d = '0;
        endcase
    end : group_results

    // --------------------
    // Stage registers
    // --------------------
    logic [XLEN-1:0]   shadd_q, cmp_q, ext_q, rot_q, byte_q, logic_q;
    logic [XLEN_LOG:0] count_q;
    bmu_valid_uop_t    op_type_q;

    // Payload only loads on a valid request
    always_ff @(posedge clk_i) begin : payload_stage
        if (req_valid_i) begin
            shadd_q <= shadd_d;
            count_q <= count_d;
            cmp_q   <= cmp_d;
            ext_q   <= ext_d;
            rot_q   <= rot_d;
            byte_q  <= byte_d;
            logic_q <= logic_d;
        end
    end : payload_stage

    always_ff @(posedge clk_i) begin : control_stage
        if (!rst_n_i) begin
            op_type_q    <= SHADD;
            data_valid_o <= 1'b0;
        end else begin
            if (req_valid_i) op_type_q <= req_i.uop.op_type;
            data_valid_o <= req_valid_i;
        end
    end : control_stage

    // Final mux driven by the registered group
    always_comb begin : result_mux
        case (op_type_q)
            SHADD:   result_o.word32 = shadd_q;
            COUNT:   result_o.word32 = {{(XLEN-XLEN_LOG-1){1'b0}}, count_q};
            COMPARE: result_o.word32 = cmp_q;
            EXTEND:  result_o.word32 = ext_q;
            ROTATE:  result_o.word32 = rot_q;
            BYTEOP:  result_o.word32 = byte_q;
            LOGICOP: result_o.word32 = logic_q;
            default: result_o.word32 = '0;
        endcase
    end : result_mux

endmodule : bit_manipulation_unit

`default_nettype wire

// ==== rtl/bmu_result_buffer.sv ====
`default_nettype none

module bmu_result_buffer (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,
    input  wire logic                        wr_valid_i,
    input  wire apogeo_data_pkg::data_word_t wr_data_i,
    input  wire logic                        pop_i,
    output logic                             rd_valid_o,
    output apogeo_data_pkg::data_word_t      rd_data_o,
    output logic                             credit_o
);

    import apogeo_data_pkg::*;

    data_word_t           mem [BMU_CREDITS];
    logic [BMU_PTR_W-1:0] wr_ptr;
    logic [BMU_PTR_W-1:0] rd_ptr;
    // One bit wider than the pointers to hold a full count
    logic [BMU_PTR_W:0]   count;
    logic                 pop;

    // Pop on an empty buffer is dropped
    assign pop = pop_i & rd_valid_o;

    // Head shown ahead of the pop
    assign rd_valid_o = (count != '0);
    assign rd_data_o  = mem[rd_ptr];

    always_ff @(posedge clk_i) begin : storage
        if (wr_valid_i) mem[wr_ptr] <= wr_data_i;
    end : storage

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_i) begin : pointers
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (wr_valid_i) wr_ptr <= wr_ptr + 1'b1;
            if (pop)        rd_ptr <= rd_ptr + 1'b1;
            count    <= count + {{BMU_PTR_W{1'b0}}, wr_valid_i} - {{BMU_PTR_W{1'b0}}, pop};
            // Freed slot goes back to the sender one cycle later
            credit_o <= pop;
        end
    end : pointers

endmodule : bmu_result_buffer

`default_nettype wire

// ==== rtl/apogeo_bmu_top.sv ====
`default_nettype none

module apogeo_bmu_top (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   req_valid_i,
    input  wire bmu_op_pkg::bmu_req_t   req_i,
    output logic                        rsp_valid_o,
    output apogeo_data_pkg::data_word_t rsp_data_o,
    input  wire logic                   rsp_pop_i,
    output logic                        credit_o
);

    import apogeo_data_pkg::*;

    // Unit output register into the buffer's write port
    data_word_t bmu_result;
    logic       bmu_valid;

    bit_manipulation_unit u_bmu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .result_o     (bmu_result),
        .data_valid_o (bmu_valid)
    );

    bmu_result_buffer u_buffer (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_valid_i (bmu_valid),
        .wr_data_i  (bmu_result),
        .pop_i      (rsp_pop_i),
        .rd_valid_o (rsp_valid_o),
        .rd_data_o  (rsp_data_o),
        .credit_o   (credit_o)
    );

endmodule : apogeo_bmu_top

`default_nettype wire

// ==== verification/apogeo_bmu_asserts.sv ====
`default_nettype none

module apogeo_bmu_asserts (
    input wire logic clk_i,
    input wire logic rst_n_i,
    input wire logic wr_valid_i,
    input wire logic rsp_valid_i,
    input wire logic rsp_pop_i,
    input wire logic credit_i
);

    import apogeo_data_pkg::*;

    // Occupancy seen from the buffer's write and pop traffic
    int occupancy;

    always @(posedge clk_i) begin
        if (!rst_n_i) occupancy <= 0;
        else occupancy <= occupancy + (wr_valid_i ? 1 : 0) - ((rsp_pop_i && rsp_valid_i) ? 1 : 0);
    end

    a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        occupancy <= BMU_CREDITS) else $error("result buffer overflow");

    // Every credit comes from an accepted pop one cycle before
    a_credit_after_pop : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_i |-> $past(rsp_pop_i && rsp_valid_i)) else $error("credit without pop");

    a_empty_after_reset : assert property (@(posedge clk_i)
        !rst_n_i |=> !rsp_valid_i) else $error("rsp_valid high after reset");

endmodule : apogeo_bmu_asserts

bind apogeo_bmu_top apogeo_bmu_asserts u_asserts (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wr_valid_i  (bmu_valid),
    .rsp_valid_i (rsp_valid_o),
    .rsp_pop_i   (rsp_pop_i),
    .credit_i    (credit_o)
);

`default_nettype wire

// ==== verification/apogeo_bmu_tb.sv ====
`default_nettype none

module apogeo_bmu_tb;

    import apogeo_data_pkg::*;
    import bmu_op_pkg::*;

    // Pops held off this long so the sender runs dry of credits
    localparam int STALL_CYCLES = 40;

    // One table row, request and the result it must produce
    typedef struct packed {
        bmu_req_t        req;
        logic [XLEN-1:0] expected;
    } entry_t;

    logic       clk       = 1'b0;
    logic       rst_n     = 1'b0;
    logic       req_valid = 1'b0;
    bmu_req_t   req       = '0;
    logic       rsp_pop   = 1'b0;
    logic       rsp_valid;
    logic       credit;
    data_word_t rsp_data;

    entry_t test_table[$];
    int     sent_idx;
    int     pop_idx;
    int     credits;
    int     max_outstanding;
    int     credit_pulses;
    int     cycles;
    int     errors;
    int     timeout_limit = 100;

    apogeo_bmu_top u_dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_data_o  (rsp_data),
        .rsp_pop_i   (rsp_pop),
        .credit_o    (credit)
    );

    initial begin : clock_gen
        forever #4 clk = ~clk;
    end : clock_gen

    task automatic add_entry(input bmu_valid_uop_t grp, input logic [2:0] op,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] expected);
        entry_t e;
        e.req.operand_a.word32 = a;
        e.req.operand_b.word32 = b;
        e.req.uop.op_type      = grp;
        e.req.uop.opcode       = op;
        e.expected             = expected;
        test_table.push_back(e);
    endtask : add_entry

    // --------------------
    // Stimulus table
    // --------------------
    task automatic build_table();
        add_entry(SHADD,   SH1ADD, 32'h0000_0010, 32'h0000_0003, 32'h0000_0023);
        add_entry(SHADD,   SH2ADD, 32'h1234_5678, 32'h0000_0001, 32'h48d1_59e1);
        // Shifted operand loses its top bits
        add_entry(SHADD,   SH3ADD, 32'hf000_0001, 32'h0000_0010, 32'h8000_0018);
        add_entry(LOGICOP, ANDN,   32'hff00_ff00, 32'h0f0f_0f0f, 32'hf000_f000);
        add_entry(LOGICOP, ORN,    32'h1234_0000, 32'hffff_0f0f, 32'h1234_f0f0);
        add_entry(LOGICOP, XNOR,   32'haaaa_5555, 32'ha5a5_a5a5, 32'hf0f0_0f0f);
        // Index bits above 4 are ignored
        add_entry(LOGICOP, BCLR,   32'hffff_ffff, 32'h0000_0023, 32'hffff_fff7);
        add_entry(LOGICOP, BEXT,   32'h8000_0000, 32'h0000_001f, 32'h0000_0001);
        add_entry(LOGICOP, BINV,   32'h0000_0001, 32'h0000_0040, 32'h0000_0000);
        add_entry(LOGICOP, BSET,   32'h0000_0000, 32'h0000_0010, 32'h0001_0000);
        // All-zero and all-ones operands
        add_entry(COUNT,   CLZ,    32'h0000_0000, 32'h0,         32'h0000_0020);
        add_entry(COUNT,   CTZ,    32'h0000_0000, 32'h0,         32'h0000_0020);
        add_entry(COUNT,   CPOP,   32'h0000_0000, 32'h0,         32'h0000_0000);
        add_entry(COUNT,   CLZ,    32'hffff_ffff, 32'h0,         32'h0000_0000);
        add_entry(COUNT,   CTZ,    32'hffff_ffff, 32'h0,         32'h0000_0000);
        add_entry(COUNT,   CPOP,   32'hffff_ffff, 32'h0,         32'h0000_0020);
        add_entry(COUNT,   CLZ,    32'h0000_1000, 32'h0,         32'h0000_0013);
        add_entry(COUNT,   CTZ,    32'h0000_1000, 32'h0,         32'h0000_000c);
        add_entry(COUNT,   CPOP,   32'h1234_5678, 32'h0,         32'h0000_000d);
        // Top bit set, signed and unsigned order differ
        add_entry(COMPARE, MAX,    32'h8000_0000, 32'h0000_0001, 32'h0000_0001);
        add_entry(COMPARE, MAXU,   32'h8000_0000, 32'h0000_0001, 32'h8000_0000);
        add_entry(COMPARE, MIN,    32'h8000_0000, 32'h0000_0001, 32'h8000_0000);
        add_entry(COMPARE, MINU,   32'h8000_0000, 32'h0000_0001, 32'h0000_0001);
        add_entry(EXTEND,  SEXTB,  32'h1234_5680, 32'h0,         32'hffff_ff80);
        add_entry(EXTEND,  SEXTH,  32'h1234_8001, 32'h0,         32'hffff_8001);
        add_entry(EXTEND,  ZEXTH,  32'hffff_8001, 32'h0,         32'h0000_8001);
        add_entry(ROTATE,  ROL,    32'h8000_0001, 32'h0000_0000, 32'h8000_0001);
        add_entry(ROTATE,  ROL,    32'h8000_0001, 32'h0000_0001, 32'h0000_0003);
        add_entry(ROTATE,  ROL,    32'h8000_0001, 32'h0000_001f, 32'hc000_0000);
        add_entry(ROTATE,  ROR,    32'h8000_0001, 32'h0000_0000, 32'h8000_0001);
        add_entry(ROTATE,  ROR,    32'h8000_0001, 32'h0000_0001, 32'hc000_0000);
        add_entry(ROTATE,  ROR,    32'h8000_0001, 32'h0000_001f, 32'h0000_0003);
        add_entry(BYTEOP,  ORCB,   32'h0080_0100, 32'h0,         32'h00ff_ff00);
        add_entry(BYTEOP,  REV8,   32'h1234_5678, 32'h0,         32'h7856_3412);
    endtask : build_table

    // --------------------
    // Sender with credits
    // --------------------
    always @(posedge clk) begin : sender
        int avail;
        // A credit pulse in the cycle just ended is usable at once
        avail = credits + (credit ? 1 : 0);
        if (!rst_n) begin
            credits   <= BMU_CREDITS;
            sent_idx  <= 0;
            req_valid <= 1'b0;
        end else if (sent_idx < test_table.size() && avail > 0) begin
            req_valid <= 1'b1;
            req       <= test_table[sent_idx].req;
            sent_idx  <= sent_idx + 1;
            credits   <= avail - 1;
        end else begin
            req_valid <= 1'b0;
            credits   <= avail;
        end
    end : sender

    // Consumer, checks each popped head in request order
    always @(posedge clk) begin : consumer
        logic [XLEN-1:0] expected;
        if (!rst_n) begin
            rsp_pop <= 1'b0;
            pop_idx <= 0;
        end else begin
            if (rsp_pop && rsp_valid) begin
                assert (pop_idx < test_table.size()) else begin
                    errors++;
                    $display("Result popped after all requests were answered");
                end
                if (pop_idx < test_table.size()) begin
                    expected = test_table[pop_idx].expected;
                    assert (rsp_data.word32 == expected) else begin
                        errors++;
                        $display("Fail rsp_data_o entry %0d: got %h expected %h",
                                 pop_idx, rsp_data.word32, expected);
                    end
                end
                pop_idx <= pop_idx + 1;
            end
            // Random stalls once the long stall is over
            rsp_pop <= (cycles > STALL_CYCLES) && (($urandom % 4) != 0);
        end
    end : consumer

    always @(posedge clk) begin : flow_monitor
        int outstanding;
        outstanding = sent_idx - pop_idx;
        if (rst_n) begin
            assert (outstanding <= BMU_CREDITS) else begin
                errors++;
                $display("Sender has more requests outstanding than the buffer holds");
            end
            if (outstanding > max_outstanding) max_outstanding <= outstanding;
            if (credit) credit_pulses <= credit_pulses + 1;
        end
    end : flow_monitor

    always @(posedge clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Timeout with %0d of %0d results received", pop_idx, test_table.size());
            $display("Test failures found");
            $finish;
        end
    end : watchdog

    initial begin : main
        void'($urandom(32'hbfed_2472));
        build_table();
        timeout_limit = 8 * test_table.size() + 100;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!rsp_valid && !credit) else begin
            errors++;
            $display("rsp_valid_o or credit_o is high right after reset");
        end
        wait (pop_idx == test_table.size());
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (credit_pulses == pop_idx) else begin
            errors++;
            $display("Fail credit_o pulses: got %h expected %h", credit_pulses, pop_idx);
        end
        assert (max_outstanding == BMU_CREDITS) else begin
            errors++;
            $display("Sender never reached a full set of outstanding requests");
        end
        assert (!rsp_valid) else begin
            errors++;
            $display("Buffer still holds a result after the last pop");
        end
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end : main

endmodule : apogeo_bmu_tb

`default_nettype wire

// ==== apogeo_bmu.f ====
common/apogeo_data_pkg.sv
common/bmu_op_pkg.sv
bit_manipulation/count_leading_zeros.sv
bit_manipulation/population_count.sv
bit_manipulation/bit_manipulation_unit.sv
rtl/bmu_result_buffer.sv
rtl/apogeo_bmu_top.sv
verification/apogeo_bmu_asserts.sv
verification/apogeo_bmu_tb.sv

// ==== Makefile ====
TOP   = apogeo_bmu_tb
BUILD = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f apogeo_bmu.f --top-module $(TOP) -Mdir $(BUILD) -o $(TOP)

run: compile
	-./$(BUILD)/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Test failures found" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed!" sim.log; then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) sim.log
